// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0
LINTFLAGS ?= --lint-only -Wall
TOP       ?= tb_lr35902
RTL_TOP   ?= lr35902_core
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: alu.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module alu (
	input  logic [`CPU_DATA_W-1:0] a,
	input  logic [`CPU_DATA_W-1:0] operand,
	input  cpu_pkg::alu_op_e       alu_op,
	input  logic [3:0]             f,
	output logic [`CPU_DATA_W-1:0] result,
	output logic [3:0]             flags_out
);

	logic                 carry_in; // Carry or borrow for ADC and SBC.
	logic [`CPU_DATA_W:0] wide;     // Result with carry in the top bit.
	logic [4:0]           nibble;   // Low nibble with half carry in bit 4.

	always_comb
	begin
		carry_in  = 1'b0;
		wide      = '0;
		nibble    = '0;
		result    = a;
		flags_out = f; // Unused codes change nothing.
		case (alu_op)
			cpu_pkg::op_add, cpu_pkg::op_adc:
			begin
				carry_in = (alu_op == cpu_pkg::op_adc) && f[`FLAG_C];
				wide     = {1'b0, a} + {1'b0, operand} + {{`CPU_DATA_W{1'b0}}, carry_in};
				nibble   = {1'b0, a[3:0]} + {1'b0, operand[3:0]} + {4'b0, carry_in};
				result   = wide[`CPU_DATA_W-1:0];
				flags_out[`FLAG_N] = 1'b0;
				flags_out[`FLAG_H] = nibble[4]; // Carry out of bit 3.
				flags_out[`FLAG_C] = wide[`CPU_DATA_W];
			end
			cpu_pkg::op_sub, cpu_pkg::op_sbc, cpu_pkg::op_cp:
			begin
				carry_in = (alu_op == cpu_pkg::op_sbc) && f[`FLAG_C];
				wide     = {1'b0, a} - {1'b0, operand} - {{`CPU_DATA_W{1'b0}}, carry_in};
				nibble   = {1'b0, a[3:0]} - {1'b0, operand[3:0]} - {4'b0, carry_in};
				result   = (alu_op == cpu_pkg::op_cp) ? a : wide[`CPU_DATA_W-1:0]; // CP keeps A.
				flags_out[`FLAG_N] = 1'b1;
				flags_out[`FLAG_H] = nibble[4]; // Borrow into bit 4.
				flags_out[`FLAG_C] = wide[`CPU_DATA_W]; // Borrow.
			end
			cpu_pkg::op_and, cpu_pkg::op_xor, cpu_pkg::op_or:
			begin
				if (alu_op == cpu_pkg::op_and)
					result = a & operand;
				else if (alu_op == cpu_pkg::op_xor)
					result = a ^ operand;
				else
					result = a | operand;
				flags_out[`FLAG_N] = 1'b0;
				flags_out[`FLAG_H] = (alu_op == cpu_pkg::op_and); // Set by AND only.
				flags_out[`FLAG_C] = 1'b0;
			end
			cpu_pkg::op_inc, cpu_pkg::op_dec:
			begin
				if (alu_op == cpu_pkg::op_inc)
				begin
					wide   = {1'b0, operand} + {{`CPU_DATA_W{1'b0}}, 1'b1};
					nibble = {1'b0, operand[3:0]} + 5'd1;
				end
				else
				begin
					wide   = {1'b0, operand} - {{`CPU_DATA_W{1'b0}}, 1'b1};
					nibble = {1'b0, operand[3:0]} - 5'd1;
				end
				result = wide[`CPU_DATA_W-1:0];
				flags_out[`FLAG_N] = (alu_op == cpu_pkg::op_dec);
				flags_out[`FLAG_H] = nibble[4];
				flags_out[`FLAG_C] = f[`FLAG_C]; // Carry kept.
			end
			default: ;
		endcase
		// Zero of the difference for CP, of the result otherwise.
		if (alu_op == cpu_pkg::op_cp)
			flags_out[`FLAG_Z] = (wide[`CPU_DATA_W-1:0] == '0);
		else if (alu_op <= cpu_pkg::op_dec)
			flags_out[`FLAG_Z] = (result == '0);
	end

endmodule

// File: build.f
+incdir+.
cpu_pkg.sv
phase_counter.sv
bus_interface.sv
register_file.sv
alu.sv
sequencer.sv
lr35902_core.sv
tb_lr35902.sv

// File: bus_interface.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module bus_interface (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [1:0]             phase,
	input  cpu_pkg::state_e        state,
	input  logic [`CPU_ADDR_W-1:0] pc,
	input  logic [`CPU_ADDR_W-1:0] hl,
	input  logic [`CPU_DATA_W-1:0] store_data,
	input  logic [`CPU_DATA_W-1:0] din,
	output logic [`CPU_ADDR_W-1:0] adr,
	output logic [`CPU_DATA_W-1:0] dout,
	output logic                   ddrv,
	output logic                   read,
	output logic                   write,
	output logic                   inc_pc,
	output logic [`CPU_DATA_W-1:0] op,
	output logic [`CPU_DATA_W-1:0] imml,
	output logic [`CPU_DATA_W-1:0] immh
);

	logic fetch_cycle; // Read at PC.
	logic read_cycle;  // Any read cycle.
	logic store_cycle; // Write at HL.

	assign fetch_cycle = (state == cpu_pkg::st_ifetch) || (state == cpu_pkg::st_imml_fetch)
		|| (state == cpu_pkg::st_immh_fetch);
	assign read_cycle  = fetch_cycle || (state == cpu_pkg::st_indirect_fetch);
	assign store_cycle = (state == cpu_pkg::st_indirect_store);
	assign inc_pc      = fetch_cycle && (phase == 2'd1); // PC steps with the read strobe.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobe schedule
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			read  <= 1'b0; // Bus idle.
			write <= 1'b0;
			ddrv  <= 1'b0;
		end
		else
		begin
			case (phase)
				2'd0:
				begin
					if (read_cycle)
						ddrv <= 1'b0; // Release data lines.
					if (store_cycle)
						ddrv <= 1'b1; // Drive dout.
				end
				2'd1:
				begin
					if (read_cycle)
						read <= 1'b1; // Request the byte.
					if (store_cycle)
						write <= 1'b1; // Single-clock write pulse.
				end
				2'd2:
				begin
					write <= 1'b0; // End write.
				end
				default:
				begin
					read <= 1'b0; // End read.
				end
			endcase
		end
	end

	// Address, write data and captured bytes.
	always_ff @(posedge clk)
	begin
		if (phase == 2'd0 && fetch_cycle)
			adr <= pc; // Fetch address.
		if (phase == `PHASE_LAST)
		begin
			adr  <= hl;         // Staged for an indirect cycle ahead.
			dout <= store_data; // Same for LD (HL),r.
		end
		if (phase == 2'd2)
		begin
			case (state)
				cpu_pkg::st_ifetch:         op   <= din;
				cpu_pkg::st_imml_fetch:     imml <= din;
				cpu_pkg::st_indirect_fetch: imml <= din; // Memory operand.
				cpu_pkg::st_immh_fetch:     immh <= din;
				default: ;
			endcase
		end
	end

endmodule

// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus and register widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CPU_ADDR_W 16 // Address bus and PC.
`define CPU_DATA_W 8  // Data bus and 8-bit registers.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flag bit positions in the 4-bit flag vector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FLAG_Z 3 // Zero.
`define FLAG_N 2 // Subtract.
`define FLAG_H 1 // Half carry.
`define FLAG_C 0 // Carry.

`define RESET_PC   16'h0000 // First opcode address.
`define PHASE_LAST 2'd3     // Four clocks per machine cycle.

`endif

// File: cpu_pkg.sv
package cpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Machine-cycle kinds
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		st_ifetch,         // Opcode read at PC.
		st_imml_fetch,     // Low immediate byte at PC.
		st_immh_fetch,     // High immediate byte at PC.
		st_indirect_fetch, // Data read at HL.
		st_indirect_store, // Data write at HL.
		st_jump            // Internal cycle for a taken jump.
	} state_e;

	// Codes 0 to 7 match opcode bits 5:3 of the ALU group.
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_adc = 4'd1,
		op_sub = 4'd2,
		op_sbc = 4'd3,
		op_and = 4'd4,
		op_xor = 4'd5,
		op_or  = 4'd6,
		op_cp  = 4'd7,
		op_inc = 4'd8, // Operand plus one.
		op_dec = 4'd9  // Operand minus one.
	} alu_op_e;

	// Register field encoding of the opcode.
	typedef enum logic [2:0] {
		r_b      = 3'd0,
		r_c      = 3'd1,
		r_d      = 3'd2,
		r_e      = 3'd3,
		r_h      = 3'd4,
		r_l      = 3'd5,
		r_hl_mem = 3'd6, // Byte read through HL.
		r_a      = 3'd7
	} reg_sel_e;

	typedef enum logic [1:0] {
		wb_alu, // ALU result.
		wb_src, // Selected source register.
		wb_imm  // Captured immediate byte.
	} wb_sel_e;

endpackage

// File: lr35902_core.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module lr35902_core (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`CPU_DATA_W-1:0] din,
	output logic [`CPU_ADDR_W-1:0] adr,
	output logic [`CPU_DATA_W-1:0] dout,
	output logic                   ddrv,
	output logic                   read,
	output logic                   write,
	output logic [`CPU_ADDR_W-1:0] pc,
	output logic [3:0]             f
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Internal nets
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic [1:0]             phase;
	logic                   last_phase;
	cpu_pkg::state_e        state;
	logic                   inc_pc;
	logic [`CPU_DATA_W-1:0] op, imml, immh;
	logic [`CPU_ADDR_W-1:0] hl;
	logic [`CPU_DATA_W-1:0] a, src;
	logic                   reg_we, flag_we, load_pc, pc_relative;
	cpu_pkg::reg_sel_e      reg_dst, src_sel;
	cpu_pkg::wb_sel_e       wb_sel;
	cpu_pkg::alu_op_e       alu_op;
	logic [`CPU_DATA_W-1:0] alu_result;
	logic [3:0]             alu_flags;

	phase_counter i_phase_counter (
		.clk(clk), .reset(reset), .phase(phase), .last_phase(last_phase)
	);

	bus_interface i_bus_interface (
		.clk(clk), .reset(reset), .phase(phase), .state(state),
		.pc(pc), .hl(hl), .store_data(src), .din(din), // Store data is the LD source.
		.adr(adr), .dout(dout), .ddrv(ddrv), .read(read), .write(write),
		.inc_pc(inc_pc), .op(op), .imml(imml), .immh(immh)
	);

	register_file i_register_file (
		.clk(clk), .reset(reset), .inc_pc(inc_pc), .load_pc(load_pc),
		.pc_relative(pc_relative), .imml(imml), .immh(immh),
		.reg_we(reg_we), .reg_dst(reg_dst), .wb_sel(wb_sel), .src_sel(src_sel),
		.alu_result(alu_result), .flag_we(flag_we), .flags_in(alu_flags),
		.src(src), .a(a), .hl(hl), .f(f), .pc(pc)
	);

	alu i_alu (
		.a(a), .operand(src), .alu_op(alu_op), .f(f),
		.result(alu_result), .flags_out(alu_flags)
	);

	sequencer i_sequencer (
		.clk(clk), .reset(reset), .last_phase(last_phase), .op(op), .f(f),
		.state(state), .reg_we(reg_we), .reg_dst(reg_dst), .wb_sel(wb_sel),
		.src_sel(src_sel), .alu_op(alu_op), .flag_we(flag_we),
		.load_pc(load_pc), .pc_relative(pc_relative)
	);

endmodule

// File: phase_counter.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module phase_counter (
	input  logic       clk,
	input  logic       reset,
	output logic [1:0] phase,     // Current phase of the machine cycle.
	output logic       last_phase // High in the final phase only.
);

	assign last_phase = (phase == `PHASE_LAST); // Commit point of each cycle.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= 2'd0; // Start a fresh machine cycle.
		end
		else if (last_phase)
		begin
			phase <= 2'd0; // Wrap to phase 0.
		end
		else
		begin
			phase <= phase + 2'd1; // Next phase.
		end
	end

endmodule

// File: register_file.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module register_file (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   inc_pc,
	input  logic                   load_pc,
	input  logic                   pc_relative,
	input  logic [`CPU_DATA_W-1:0] imml,
	input  logic [`CPU_DATA_W-1:0] immh,
	input  logic                   reg_we,
	input  cpu_pkg::reg_sel_e      reg_dst,
	input  cpu_pkg::wb_sel_e       wb_sel,
	input  cpu_pkg::reg_sel_e      src_sel,
	input  logic [`CPU_DATA_W-1:0] alu_result,
	input  logic                   flag_we,
	input  logic [3:0]             flags_in,
	output logic [`CPU_DATA_W-1:0] src,
	output logic [`CPU_DATA_W-1:0] a,
	output logic [`CPU_ADDR_W-1:0] hl,
	output logic [3:0]             f,
	output logic [`CPU_ADDR_W-1:0] pc
);

	logic [`CPU_DATA_W-1:0] b, c, d, e, h, l;
	logic [`CPU_DATA_W-1:0] wb_data; // Value written to reg_dst.
	logic [`CPU_ADDR_W-1:0] pc_step; // Increment or signed offset.
	logic [`CPU_ADDR_W-1:0] pc_sum;  // Single 16-bit adder.

	assign hl = {h, l};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Source and write-back muxes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		src = a;
		case (src_sel)
			cpu_pkg::r_b:      src = b;
			cpu_pkg::r_c:      src = c;
			cpu_pkg::r_d:      src = d;
			cpu_pkg::r_e:      src = e;
			cpu_pkg::r_h:      src = h;
			cpu_pkg::r_l:      src = l;
			cpu_pkg::r_hl_mem: src = imml; // Byte fetched through HL.
			default:           src = a;
		endcase
		case (wb_sel)
			cpu_pkg::wb_alu: wb_data = alu_result;
			cpu_pkg::wb_imm: wb_data = imml;
			default:         wb_data = src; // Register to register.
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			a <= '0;
			b <= '0;
			c <= '0;
			d <= '0;
			e <= '0;
			h <= '0;
			l <= '0;
			f <= '0;
		end
		else
		begin
			if (reg_we)
			begin
				case (reg_dst)
					cpu_pkg::r_b: b <= wb_data;
					cpu_pkg::r_c: c <= wb_data;
					cpu_pkg::r_d: d <= wb_data;
					cpu_pkg::r_e: e <= wb_data;
					cpu_pkg::r_h: h <= wb_data;
					cpu_pkg::r_l: l <= wb_data;
					cpu_pkg::r_a: a <= wb_data;
					default: ; // No register behind (HL).
				endcase
			end
			if (flag_we)
				f <= flags_in; // ALU flags.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign pc_step = pc_relative ? {{(`CPU_ADDR_W-`CPU_DATA_W){imml[`CPU_DATA_W-1]}}, imml}
		: `CPU_ADDR_W'(1);
	assign pc_sum  = pc + pc_step;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= `RESET_PC;
		else if (load_pc)
			pc <= {immh, imml}; // Absolute jump.
		else if (inc_pc || pc_relative)
			pc <= pc_sum; // Step or relative jump.
	end

endmodule

// File: sequencer.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module sequencer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   last_phase,
	input  logic [`CPU_DATA_W-1:0] op,
	input  logic [3:0]             f,
	output cpu_pkg::state_e        state,
	output logic                   reg_we,
	output cpu_pkg::reg_sel_e      reg_dst,
	output cpu_pkg::wb_sel_e       wb_sel,
	output cpu_pkg::reg_sel_e      src_sel,
	output cpu_pkg::alu_op_e       alu_op,
	output logic                   flag_we,
	output logic                   load_pc,
	output logic                   pc_relative
);

	cpu_pkg::state_e next_state;
	logic wr_reg;   // Register write at the end of this cycle.
	logic wr_flags; // Flag write at the end of this cycle.
	logic jump_abs; // PC from immh and imml.
	logic jump_rel; // PC plus signed imml.

	logic is_ld_rr, is_ld_imm, is_alu, is_incdec, is_jp, is_jr;
	logic src_is_mem, dst_is_mem;
	logic cond_met, taken;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcode groups
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign src_is_mem = (op[2:0] == 3'b110);
	assign dst_is_mem = (op[5:3] == 3'b110);
	assign is_ld_rr   = (op[7:6] == 2'b01) && (op != 8'h76); // 0x76 runs as a no-op.
	assign is_ld_imm  = (op[7:6] == 2'b00) && src_is_mem && !dst_is_mem; // LD r,d8.
	assign is_alu     = (op[7:6] == 2'b10) || ((op[7:6] == 2'b11) && src_is_mem);
	assign is_incdec  = (op[7:6] == 2'b00) && (op[2:1] == 2'b10) && !dst_is_mem;
	assign is_jp      = (op == 8'hc3) || ((op[7:5] == 3'b110) && (op[2:0] == 3'b010));
	assign is_jr      = (op == 8'h18) || ((op[7:5] == 3'b001) && (op[2:0] == 3'b000));

	// Condition field 4:3 selects NZ, Z, NC or C.
	assign cond_met = ((op[4] ? f[`FLAG_C] : f[`FLAG_Z]) == op[3]);
	assign taken    = (op == 8'hc3) || (op == 8'h18) || cond_met;

	always_comb
	begin
		next_state = cpu_pkg::st_ifetch; // Most instructions end here.
		wr_reg     = 1'b0;
		wr_flags   = 1'b0;
		jump_abs   = 1'b0;
		jump_rel   = 1'b0;
		reg_dst    = cpu_pkg::reg_sel_e'(op[5:3]);
		src_sel    = cpu_pkg::reg_sel_e'(op[2:0]); // Immediate forms also land on r_hl_mem.
		wb_sel     = cpu_pkg::wb_src;
		alu_op     = cpu_pkg::alu_op_e'({1'b0, op[5:3]});
		if (is_ld_rr)
		begin
			if (src_is_mem && state == cpu_pkg::st_ifetch)
				next_state = cpu_pkg::st_indirect_fetch; // Read (HL) first.
			else if (dst_is_mem)
			begin
				if (state == cpu_pkg::st_ifetch)
					next_state = cpu_pkg::st_indirect_store; // Write source to (HL).
			end
			else
				wr_reg = 1'b1;
		end
		else if (is_ld_imm)
		begin
			if (state == cpu_pkg::st_ifetch)
				next_state = cpu_pkg::st_imml_fetch;
			else
			begin
				wr_reg = 1'b1;
				wb_sel = cpu_pkg::wb_imm;
			end
		end
		else if (is_alu)
		begin
			if (src_is_mem && state == cpu_pkg::st_ifetch)
				next_state = op[6] ? cpu_pkg::st_imml_fetch : cpu_pkg::st_indirect_fetch;
			else
			begin
				wr_flags = 1'b1;
				wr_reg   = (alu_op != cpu_pkg::op_cp); // CP leaves A.
				reg_dst  = cpu_pkg::r_a;
				wb_sel   = cpu_pkg::wb_alu;
			end
		end
		else if (is_incdec)
		begin
			wr_reg   = 1'b1;
			wr_flags = 1'b1;
			wb_sel   = cpu_pkg::wb_alu;
			src_sel  = cpu_pkg::reg_sel_e'(op[5:3]); // Operand is the target itself.
			alu_op   = op[0] ? cpu_pkg::op_dec : cpu_pkg::op_inc;
		end
		else if (is_jp || is_jr)
		begin
			case (state)
				cpu_pkg::st_ifetch:
					next_state = cpu_pkg::st_imml_fetch;
				cpu_pkg::st_imml_fetch:
				begin
					if (is_jp)
						next_state = cpu_pkg::st_immh_fetch;
					else if (taken)
						next_state = cpu_pkg::st_jump; // JR offset in hand.
				end
				cpu_pkg::st_immh_fetch:
				begin
					if (taken)
						next_state = cpu_pkg::st_jump; // JP target in hand.
				end
				cpu_pkg::st_jump:
				begin
					jump_abs = is_jp;
					jump_rel = is_jr;
				end
				default: ;
			endcase
		end
	end

	// Commit once per machine cycle.
	assign reg_we      = wr_reg && last_phase;
	assign flag_we     = wr_flags && last_phase;
	assign load_pc     = jump_abs && last_phase;
	assign pc_relative = jump_rel && last_phase;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= cpu_pkg::st_ifetch;
		else if (last_phase)
			state <= next_state; // Advance at phase 3.
	end

endmodule

// File: tb_lr35902.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module tb_lr35902;

	localparam int MAX_ENTRIES = 48;
	localparam int PROG_LEN    = 12;

	logic        clk;
	logic        reset;
	logic [7:0]  din;
	logic [15:0] adr;
	logic [7:0]  dout;
	logic        ddrv;
	logic        read;
	logic        write;
	logic [15:0] pc;
	logic [3:0]  f;

	logic [7:0]  mem [0:65535]; // Flat 64 KiB memory.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic [7:0]  prog [0:MAX_ENTRIES-1][0:PROG_LEN-1];
	int          plen [0:MAX_ENTRIES-1];
	string       name [0:MAX_ENTRIES-1];
	logic [15:0] exp_adr [0:MAX_ENTRIES-1];
	logic [7:0]  exp_dat [0:MAX_ENTRIES-1];
	logic [3:0]  exp_fl  [0:MAX_ENTRIES-1];
	logic        has_pre [0:MAX_ENTRIES-1]; // Byte preloaded behind HL.
	logic [7:0]  pre_val [0:MAX_ENTRIES-1];

	int   n_entries = 0;
	int   cur;
	int   errors = 0;
	int   passed = 0;
	int   seed = 94206;
	int   wcnt = 0;
	logic table_ready = 1'b0;

	lr35902_core i_lr35902_core (
		.clk(clk), .reset(reset), .din(din), .adr(adr), .dout(dout),
		.ddrv(ddrv), .read(read), .write(write), .pc(pc), .f(f)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period.

	assign din = mem[adr]; // Byte ready well before capture in phase 2.

	always @(posedge clk)
	begin
		if (write)
			mem[adr] <= dout; // Store while the strobe is high.
	end

	// Strobe overlap and write width.
	always @(negedge clk)
	begin
		if (read && write)
		begin
			$display("** Error at %0t ns: read and write high together", $time);
			errors++;
		end
		if (write)
			wcnt++;
		else if (wcnt != 0)
		begin
			if (wcnt != 1)
			begin
				$display("** Error at %0t ns: write width expected 1, got %0d", $time, wcnt);
				errors++;
			end
			wcnt = 0;
		end
	end

	// Reference ALU from the flag rules; returns {result, Z N H C}.
	function automatic [11:0] alu_ref(input [3:0] code, input [7:0] x, input [7:0] y,
		input [3:0] fin);
		logic [8:0] s;
		logic [7:0] r;
		logic       cin;
		logic       z, n, h, c;
		cin = ((code == 4'd1) || (code == 4'd3)) ? fin[`FLAG_C] : 1'b0;
		n = 1'b0;
		h = 1'b0;
		c = 1'b0;
		case (code)
			4'd0, 4'd1:
			begin
				s = x + y + cin;
				r = s[7:0];
				h = ({1'b0, x[3:0]} + y[3:0] + cin) > 5'h0f;
				c = s[8];
			end
			4'd2, 4'd3, 4'd7:
			begin
				r = x - y - cin;
				n = 1'b1;
				h = {1'b0, x[3:0]} < ({1'b0, y[3:0]} + cin);
				c = {1'b0, x} < ({1'b0, y} + cin);
			end
			4'd4:
			begin
				r = x & y;
				h = 1'b1;
			end
			4'd5: r = x ^ y;
			4'd6: r = x | y;
			4'd8:
			begin
				r = y + 8'd1;
				h = (y[3:0] == 4'hf);
				c = fin[`FLAG_C];
			end
			default:
			begin
				r = y - 8'd1;
				n = 1'b1;
				h = (y[3:0] == 4'h0);
				c = fin[`FLAG_C];
			end
		endcase
		z = (r == 8'h00); // CP tests the difference.
		if (code == 4'd7)
			r = x;
		alu_ref = {r, z, n, h, c};
	endfunction

	task automatic start_entry(input string nm);
		cur = n_entries;
		n_entries++;
		plen[cur] = 0;
		name[cur] = nm;
		has_pre[cur] = 1'b0;
	endtask

	task automatic put(input [7:0] b);
		prog[cur][plen[cur]] = b;
		plen[cur]++;
	endtask

	// Opcode followed by its immediate byte.
	task automatic put_pair(input [7:0] b0, input [7:0] b1);
		put(b0);
		put(b1);
	endtask

	task automatic set_expect(input [15:0] ad, input [7:0] dat, input [3:0] fl);
		exp_adr[cur] = ad;
		exp_dat[cur] = dat;
		exp_fl[cur]  = fl;
	endtask

	// Mode 0 uses B, mode 1 a d8 and mode 2 the byte at HL.
	task automatic add_alu(input [3:0] code, input [7:0] aa, input [7:0] bb, input int mode);
		logic [7:0]  hh;
		logic [7:0]  ll;
		logic [7:0]  cc;
		logic [3:0]  fin;
		logic [11:0] r;
		hh = 8'h80 | 8'($random(seed));
		ll = 8'($random(seed));
		cc = 8'($random(seed));
		fin = 4'h0;
		start_entry($sformatf("alu op%0d mode%0d a=%h b=%h", code, mode, aa, bb));
		put_pair(8'h26, hh);
		put_pair(8'h2e, ll);
		put_pair(8'h3e, aa);
		if (mode == 0)
			put_pair(8'h06, bb);
		if (code == 4'd1 || code == 4'd3)
		begin
			put_pair(8'hfe, cc); // CP d8 sets the incoming carry.
			r = alu_ref(4'd7, aa, cc, 4'h0);
			fin = r[3:0];
		end
		if (mode == 0)
			put(8'h80 | (code << 3));
		else if (mode == 1)
			put_pair(8'hc6 | (code << 3), bb);
		else
		begin
			put(8'h86 | (code << 3));
			has_pre[cur] = 1'b1;
			pre_val[cur] = bb;
		end
		put(8'h77); // LD (HL),A.
		r = alu_ref(code, aa, bb, fin);
		set_expect({hh, ll}, r[11:4], r[3:0]);
	endtask

	task automatic add_incdec(input logic dec, input [7:0] aa, input [7:0] bb);
		logic [11:0] r1;
		logic [11:0] r2;
		start_entry($sformatf("%s a=%h after cp %h", dec ? "dec" : "inc", aa, bb));
		put_pair(8'h26, 8'h90);
		put_pair(8'h2e, 8'h10);
		put_pair(8'h3e, aa);
		put_pair(8'h06, bb);
		put(8'hb8);
		put(dec ? 8'h3d : 8'h3c);
		put(8'h77);
		r1 = alu_ref(4'd7, aa, bb, 4'h0);
		r2 = alu_ref(dec ? 4'd9 : 4'd8, 8'h00, aa, r1[3:0]);
		set_expect(16'h9010, r2[11:4], r2[3:0]);
	endtask

	// Condition code 0..3 is NZ, Z, NC, C.
	task automatic add_jump(input logic rel, input [1:0] cond, input [7:0] aa, input [7:0] cc);
		logic [11:0] r;
		logic        flag;
		logic        taken;
		r = alu_ref(4'd7, aa, cc, 4'h0);
		flag = cond[1] ? r[`FLAG_C] : r[`FLAG_Z];
		taken = (flag == cond[0]);
		start_entry($sformatf("%s cc%0d a=%h cp %h", rel ? "jr" : "jp", cond, aa, cc));
		put_pair(8'h26, 8'ha0);
		put_pair(8'h3e, aa);
		put_pair(8'hfe, cc);
		if (rel)
			put_pair(8'h20 | (cond << 3), 8'h02); // Lands on 0x0a.
		else
		begin
			put(8'hc2 | (cond << 3));
			put_pair(8'h0b, 8'h00);
		end
		put(8'h77);
		put(8'h00);
		put(8'h70);
		set_expect(16'ha000, taken ? 8'h00 : aa, r[3:0]); // B is still zero.
	endtask

	task automatic check_val(input string sig, input [15:0] expv, input [15:0] act,
		inout int terr);
		if (expv !== act)
		begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, sig, expv, act);
			terr++;
		end
	endtask

	task automatic run_entry(input int k);
		int terr;
		int clocks;
		terr = 0;
		@(posedge clk);
		#1 reset = 1'b1;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'h00;
		for (int i = 0; i < plen[k]; i++)
			mem[i] = prog[k][i];
		if (has_pre[k])
			mem[exp_adr[k]] = pre_val[k];
		repeat (9) @(posedge clk);
		@(negedge clk);
		check_val("read", 16'h0, {15'h0, read}, terr);
		check_val("write", 16'h0, {15'h0, write}, terr);
		check_val("ddrv", 16'h0, {15'h0, ddrv}, terr);
		check_val("pc", 16'h0, pc, terr);
		@(posedge clk);
		#1 reset = 1'b0;
		clocks = 0;
		@(negedge clk); // No rising edge seen with reset low yet.
		while (!read)
		begin
			@(negedge clk);
			clocks++; // One more rising edge after release.
		end
		check_val("first read clock", 16'd2, clocks[15:0], terr);
		check_val("first read adr", 16'h0000, adr, terr);
		while (!write)
			@(negedge clk);
		check_val("adr", exp_adr[k], adr, terr);
		check_val("dout", {8'h0, exp_dat[k]}, {8'h0, dout}, terr);
		check_val("ddrv", 16'h1, {15'h0, ddrv}, terr);
		check_val("f", {12'h0, exp_fl[k]}, {12'h0, f}, terr);
		if (terr == 0)
		begin
			$display("PASS %s", name[k]);
			passed++;
		end
		else
			$display("FAIL %s", name[k]);
		errors += terr;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial
	begin
		reset = 1'b1;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'h00;
		start_entry("ld (hl),b");
		put_pair(8'h26, 8'h81);
		put_pair(8'h2e, 8'h23);
		put_pair(8'h06, 8'h5a);
		put(8'h70);
		set_expect(16'h8123, 8'h5a, 4'h0);
		for (int op = 0; op < 8; op++)
			add_alu(4'(op), 8'($random(seed)), 8'($random(seed)), 0);
		add_alu(4'd0, 8'hff, 8'h01, 0); // Zero, half and carry.
		add_alu(4'd0, 8'h0f, 8'h01, 0); // Half carry only.
		add_alu(4'd2, 8'h42, 8'h42, 0); // Zero difference.
		add_alu(4'd2, 8'h00, 8'h01, 0); // Borrow.
		add_alu(4'd7, 8'h10, 8'h01, 0); // Half borrow.
		add_alu(4'd4, 8'hf0, 8'h0f, 0); // AND to zero.
		add_alu(4'd5, 8'h3c, 8'h3c, 0); // XOR to zero.
		add_alu(4'd1, 8'hff, 8'h00, 0);
		for (int op = 0; op < 8; op++)
			add_alu(4'(op), 8'($random(seed)), 8'($random(seed)), 1);
		for (int op = 0; op < 4; op++)
			add_alu(4'(op * 2 + 1), 8'($random(seed)), 8'($random(seed)), 2);
		add_incdec(1'b0, 8'h0f, 8'h20);
		add_incdec(1'b0, 8'hff, 8'h01);
		add_incdec(1'b1, 8'h01, 8'h02);
		add_incdec(1'b1, 8'h10, 8'h00);
		for (int r = 0; r < 2; r++)
		begin
			add_jump(1'(r), 2'd1, 8'h85, 8'h85);
			add_jump(1'(r), 2'd1, 8'h85, 8'h84);
			add_jump(1'(r), 2'd3, 8'h85, 8'h90);
			add_jump(1'(r), 2'd3, 8'h85, 8'h10);
			add_jump(1'(r), 2'd0, 8'h85, 8'h85);
			add_jump(1'(r), 2'd2, 8'h85, 8'h10);
		end
		table_ready = 1'b1;
		for (int k = 0; k < n_entries; k++)
			run_entry(k);
		repeat (2) @(posedge clk); // Last write strobe ends and is measured.
		$display("Tests passed %0d of %0d, errors %0d", passed, n_entries, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog sized by the table length.
	initial
	begin
		wait (table_ready);
		#(n_entries * 40 * 16);
		$display("Timeout: the tests did not finish in time");
		$display("Errors found");
		$finish;
	end

endmodule
